/* rtl/mvu_pkg.sv */
// sizes are fixed at compile time; SIMD must be a power of two and FOLD_MAX must equal 2**FOLD_W
`default_nettype none

package mvu_pkg;

   localparam int SIMD     = 4;                 // lanes per PE
   localparam int PE_NUM   = 2;                 // PE instances
   localparam int T_ACT    = 4;                 // signed activation bits
   localparam int T_WGT    = 4;                 // signed weight bits
   localparam int T_DST    = 16;                // signed result and accumulator bits

   // derived widths
   localparam int T_PROD   = T_ACT + T_WGT;     // full lane product
   localparam int T_IN     = SIMD * T_ACT;      // one input beat
   localparam int T_WROW   = SIMD * T_WGT;      // one PE row for one fold

   // fold addressing
   localparam int FOLD_MAX = 8;                 // deepest dot product
   localparam int FOLD_W   = 3;                 // fold address bits

   // pe indexing
   localparam int PE_W     = 1;                 // pe index bits

   // adder tree shape
   localparam int ADD_STAGES = 1;               // registers after the tree
   localparam int ADD_LVLS   = $clog2(SIMD);    // pairwise levels

endpackage : mvu_pkg

`default_nettype wire

/* rtl/mvu_pe_adders.sv */
// SIMD must be a power of two; lane sums wrap silently at T_DST bits with no saturation
`default_nettype none

module mvu_pe_adders (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              in_v,
   input  logic                              in_last,
   input  logic signed [mvu_pkg::T_PROD-1:0] in_prod [mvu_pkg::SIMD],
   output logic                              out_v,
   output logic                              out_last,
   output logic signed [mvu_pkg::T_DST-1:0]  out_sum
);

   import mvu_pkg::*;

   logic signed [T_DST-1:0] node [0:ADD_LVLS][0:SIMD-1]; // tree nodes, level 0 = lanes
   logic signed [T_DST-1:0] sum_q [0:ADD_STAGES-1];      // pipelined tree result
   logic [ADD_STAGES-1:0]   v_q;                         // valid alongside sum
   logic [ADD_STAGES-1:0]   last_q;                      // last alongside sum

   // balanced pairwise reduction
   always_comb begin
      for (int l = 0; l <= ADD_LVLS; l++) begin
         for (int n = 0; n < SIMD; n++) begin
            node[l][n] = '0;                              // unused slots stay zero
         end
      end
      for (int k = 0; k < SIMD; k++) begin
         node[0][k] = T_DST'(in_prod[k]);                 // sign extend lane product
      end
      for (int l = 0; l < ADD_LVLS; l++) begin
         for (int n = 0; n < (SIMD >> (l + 1)); n++) begin
            node[l+1][n] = node[l][2*n] + node[l][2*n+1];
         end
      end
   end

   always_ff @(posedge clk) begin
      sum_q[0] <= node[ADD_LVLS][0];                      // root of tree
      for (int s = 1; s < ADD_STAGES; s++) begin
         sum_q[s] <= sum_q[s-1];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         v_q    <= '0;
         last_q <= '0;
      end else begin
         v_q[0]    <= in_v;
         last_q[0] <= in_v & in_last;                     // last only counts with valid
         for (int s = 1; s < ADD_STAGES; s++) begin
            v_q[s]    <= v_q[s-1];
            last_q[s] <= last_q[s-1];
         end
      end
   end

   assign out_v    = v_q[ADD_STAGES-1];
   assign out_last = last_q[ADD_STAGES-1];
   assign out_sum  = sum_q[ADD_STAGES-1];

endmodule : mvu_pe_adders

`default_nettype wire

/* rtl/mvu_pe_acc.sv */
// accumulator wraps at T_DST bits; out_acc holds the total only in the cycle out_v is high
`default_nettype none

module mvu_pe_acc (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             in_v,
   input  logic                             in_last,
   input  logic signed [mvu_pkg::T_DST-1:0] in_sum,
   output logic                             out_v,
   output logic signed [mvu_pkg::T_DST-1:0] out_acc
);

   import mvu_pkg::*;

   logic                    first_q;  // next beat starts a new dot product
   logic signed [T_DST-1:0] acc_q;    // running total over folds

   // control state
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         first_q <= 1'b1;               // first beat after reset loads
         out_v   <= 1'b0;
      end else begin
         out_v <= in_v & in_last;       // one pulse per dot product
         if (in_v) begin
            first_q <= in_last;         // restart after each last
         end
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if (in_v) begin
         if (first_q) begin
            acc_q <= in_sum;            // drop previous total
         end else begin
            acc_q <= acc_q + in_sum;
         end
      end
   end

   assign out_acc = acc_q;

endmodule : mvu_pe_acc

`default_nettype wire

/* rtl/mvu_pe.sv */
// multi-bit signed operands only; beat flags must arrive aligned with the activation and weight words
`default_nettype none

module mvu_pe (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             beat_v,
   input  logic                             beat_last,
   input  logic [mvu_pkg::T_IN-1:0]         beat_act,
   input  logic [mvu_pkg::T_WROW-1:0]       beat_wgt,
   output logic                             pe_v,
   output logic signed [mvu_pkg::T_DST-1:0] pe_result
);

   import mvu_pkg::*;

   logic signed [T_ACT-1:0]  act_lane [SIMD];  // per-lane activation
   logic signed [T_WGT-1:0]  wgt_lane [SIMD];  // per-lane weight
   logic signed [T_PROD-1:0] prod     [SIMD];  // per-lane product
   logic                     add_v;            // tree output valid
   logic                     add_last;         // tree output last
   logic signed [T_DST-1:0]  add_sum;          // lane sum for this fold

   // lane k sits at bits k*width upward in both words
   for (genvar k = 0; k < SIMD; k++) begin : g_lane
      assign act_lane[k] = beat_act[k*T_ACT +: T_ACT];
      assign wgt_lane[k] = beat_wgt[k*T_WGT +: T_WGT];
      assign prod[k]     = act_lane[k] * wgt_lane[k];  // signed, full width
   end

   // one register stage
   mvu_pe_adders mvu_pe_adders_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_v     (beat_v),
      .in_last  (beat_last),
      .in_prod  (prod),
      .out_v    (add_v),
      .out_last (add_last),
      .out_sum  (add_sum)
   );

   // one more stage, result on last fold
   mvu_pe_acc mvu_pe_acc_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .in_v    (add_v),
      .in_last (add_last),
      .in_sum  (add_sum),
      .out_v   (pe_v),
      .out_acc (pe_result)
   );

endmodule : mvu_pe

`default_nettype wire

/* rtl/mvu_wgt_mem.sv */
// weights may only be written while no stream is in progress; the fold counter wraps at FOLD_MAX
`default_nettype none

module mvu_wgt_mem (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       wgt_we,
   input  logic [mvu_pkg::PE_W-1:0]   wgt_pe,
   input  logic [mvu_pkg::FOLD_W-1:0] wgt_addr,
   input  logic [mvu_pkg::T_WROW-1:0] wgt_data,
   input  logic                       in_v,
   input  logic                       in_last,
   input  logic [mvu_pkg::T_IN-1:0]   in_act,
   output logic                       beat_v,
   output logic                       beat_last,
   output logic [mvu_pkg::T_IN-1:0]   beat_act,
   output logic [mvu_pkg::T_WROW-1:0] beat_wgt [mvu_pkg::PE_NUM]
);

   import mvu_pkg::*;

   logic [T_WROW-1:0]  mem [PE_NUM][FOLD_MAX];  // one word per pe and fold
   logic [FOLD_W-1:0]  fold_q;                  // fold of the next beat

   // write port
   always_ff @(posedge clk) begin
      if (wgt_we) begin
         mem[wgt_pe][wgt_addr] <= wgt_data;
      end
   end

   // fold counter and beat flags
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fold_q    <= '0;
         beat_v    <= 1'b0;
         beat_last <= 1'b0;
      end else begin
         beat_v    <= in_v;
         beat_last <= in_v & in_last;
         if (in_v) begin
            if (in_last) begin
               fold_q <= '0;          // next beat starts a new dot product
            end else begin
               fold_q <= fold_q + 1'b1;
            end
         end
      end
   end

   // beat payload, all rows read at the current fold
   always_ff @(posedge clk) begin
      if (in_v) begin
         beat_act <= in_act;
         for (int p = 0; p < PE_NUM; p++) begin
            beat_wgt[p] <= mem[p][fold_q];
         end
      end
   end

endmodule : mvu_wgt_mem

`default_nettype wire

/* rtl/mvu_out_arbiter.sv */
// no back-pressure; a PE must not finish again before its pending result has been granted
`default_nettype none

module mvu_out_arbiter (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             pe_v      [mvu_pkg::PE_NUM],
   input  logic signed [mvu_pkg::T_DST-1:0] pe_result [mvu_pkg::PE_NUM],
   output logic                             out_v,
   output logic [mvu_pkg::PE_W-1:0]         out_pe,
   output logic signed [mvu_pkg::T_DST-1:0] out_data
);

   import mvu_pkg::*;

   logic [PE_NUM-1:0]       pend_q;            // result waiting per pe
   logic signed [T_DST-1:0] val_q   [PE_NUM];  // held result per pe
   logic signed [T_DST-1:0] cur_val [PE_NUM];  // fresh result or held one
   logic [PE_NUM-1:0]       req;               // pending or arriving now
   logic [PE_NUM-1:0]       gnt;               // one-hot grant
   logic                    gnt_found;
   logic [PE_W-1:0]         gnt_idx;
   logic [PE_W-1:0]         ptr_q;             // last granted index

   // request vector and bypass of a result arriving this cycle
   always_comb begin
      for (int i = 0; i < PE_NUM; i++) begin
         req[i]     = pend_q[i] | pe_v[i];
         cur_val[i] = pe_v[i] ? pe_result[i] : val_q[i];
      end
   end

   // circular search starting after ptr_q
   always_comb begin
      int idx;
      gnt       = '0;
      gnt_found = 1'b0;
      gnt_idx   = ptr_q;
      for (int off = 1; off <= PE_NUM; off++) begin
         idx = (int'(ptr_q) + off) % PE_NUM;
         if (!gnt_found && req[idx]) begin
            gnt_found = 1'b1;
            gnt_idx   = PE_W'(idx);
            gnt[idx]  = 1'b1;
         end
      end
   end

   // control state
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pend_q <= '0;
         ptr_q  <= PE_W'(PE_NUM - 1);  // so pe 0 wins first
         out_v  <= 1'b0;
      end else begin
         pend_q <= req & ~gnt;          // granted bit clears
         out_v  <= gnt_found;
         if (gnt_found) begin
            ptr_q <= gnt_idx;
         end
      end
   end

   // payload
   always_ff @(posedge clk) begin
      for (int i = 0; i < PE_NUM; i++) begin
         if (pe_v[i]) begin
            val_q[i] <= pe_result[i];
         end
      end
      if (gnt_found) begin
         out_pe   <= gnt_idx;
         out_data <= cur_val[gnt_idx];
      end
   end

endmodule : mvu_out_arbiter

`default_nettype wire

/* rtl/mvu_top.sv */
// in_last at most once every PE_NUM beats; write weights only between streams; results out 4 cycles after last
`default_nettype none

module mvu_top (
   input  logic                             clk,
   input  logic                             rst_n,
   // weight load port
   input  logic                             wgt_we,
   input  logic [mvu_pkg::PE_W-1:0]         wgt_pe,
   input  logic [mvu_pkg::FOLD_W-1:0]       wgt_addr,
   input  logic [mvu_pkg::T_WROW-1:0]       wgt_data,
   // activation stream
   input  logic                             in_v,
   input  logic                             in_last,
   input  logic [mvu_pkg::T_IN-1:0]         in_act,
   // shared result bus
   output logic                             out_v,
   output logic [mvu_pkg::PE_W-1:0]         out_pe,
   output logic signed [mvu_pkg::T_DST-1:0] out_data
);

   import mvu_pkg::*;

   logic                    beat_v;                // registered input beat
   logic                    beat_last;
   logic [T_IN-1:0]         beat_act;
   logic [T_WROW-1:0]       beat_wgt  [PE_NUM];    // row per pe at this fold
   logic                    pe_v      [PE_NUM];
   logic signed [T_DST-1:0] pe_result [PE_NUM];

   mvu_wgt_mem mvu_wgt_mem_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .wgt_we    (wgt_we),
      .wgt_pe    (wgt_pe),
      .wgt_addr  (wgt_addr),
      .wgt_data  (wgt_data),
      .in_v      (in_v),
      .in_last   (in_last),
      .in_act    (in_act),
      .beat_v    (beat_v),
      .beat_last (beat_last),
      .beat_act  (beat_act),
      .beat_wgt  (beat_wgt)
   );

   // all PEs see the same beat, each with its own weights
   for (genvar g = 0; g < PE_NUM; g++) begin : g_pe
      mvu_pe mvu_pe_i (
         .clk       (clk),
         .rst_n     (rst_n),
         .beat_v    (beat_v),
         .beat_last (beat_last),
         .beat_act  (beat_act),
         .beat_wgt  (beat_wgt[g]),
         .pe_v      (pe_v[g]),
         .pe_result (pe_result[g])
      );
   end

   mvu_out_arbiter mvu_out_arbiter_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .pe_v      (pe_v),
      .pe_result (pe_result),
      .out_v     (out_v),
      .out_pe    (out_pe),
      .out_data  (out_data)
   );

endmodule : mvu_top

`default_nettype wire

/* tb/mvu_tb.sv */
// run from the project root so tb/mvu_golden.txt is found; results must appear in file order
`default_nettype none

module mvu_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import mvu_pkg::*;

   localparam int          PERIOD      = 20;                   // ns
   localparam int          RST_CYCLES  = 8;
   localparam int          CYC_PER_REC = 8;                    // watchdog budget per record
   localparam int          OUT_LAT     = 5;                    // last beat to second result
   localparam logic [31:0] SEED        = 32'he337e580;
   localparam string       GOLDEN_FILE = "tb/mvu_golden.txt";

   logic                    clk;
   logic                    rst_n;
   logic                    wgt_we;
   logic [PE_W-1:0]         wgt_pe;
   logic [FOLD_W-1:0]       wgt_addr;
   logic [T_WROW-1:0]       wgt_data;
   logic                    in_v;
   logic                    in_last;
   logic [T_IN-1:0]         in_act;
   logic                    out_v;
   logic [PE_W-1:0]         out_pe;
   logic signed [T_DST-1:0] out_data;

   string recs [$];       // golden records, comments stripped
   int    n_rec = 0;
   int    exp_pe_q  [$];  // expected pe order
   int    exp_val_q [$];  // expected totals
   logic  gap_en;         // random idle cycles after each beat

   mvu_top mvu_top_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .wgt_we   (wgt_we),
      .wgt_pe   (wgt_pe),
      .wgt_addr (wgt_addr),
      .wgt_data (wgt_data),
      .in_v     (in_v),
      .in_last  (in_last),
      .in_act   (in_act),
      .out_v    (out_v),
      .out_pe   (out_pe),
      .out_data (out_data)
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   task automatic check(input logic signed [31:0] got, input int exp, input string what);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         $display("Result: FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic bad_record(input string rec);
      $display("golden file has a record that cannot be parsed: %s", rec);
      $display("Result: FAILED");
      $fatal(1, "bad golden record");
   endtask

   // lane 0 in the low bits
   function automatic logic [T_IN-1:0] pack_lanes(input int l0, input int l1,
                                                  input int l2, input int l3);
      pack_lanes = {l3[3:0], l2[3:0], l1[3:0], l0[3:0]};
   endfunction

   task automatic load_records();
      int    fd;
      int    n;
      string line;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         $display("could not open the golden file %s", GOLDEN_FILE);
         $display("Result: FAILED");
         $fatal(1, "missing golden file");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line[0] != "#") begin  // skip blanks and comments
            recs.push_back(line);
         end
      end
      $fclose(fd);
      n_rec = recs.size();
   endtask

   task automatic write_weights(input int pe, input int fold, input logic [T_WROW-1:0] row);
      wgt_we   = 1'b1;
      wgt_pe   = PE_W'(pe);
      wgt_addr = FOLD_W'(fold);
      wgt_data = row;
      @(negedge clk);
      wgt_we   = 1'b0;
   endtask

   task automatic drive_beat(input logic [T_IN-1:0] act, input logic last);
      int gap;
      in_v    = 1'b1;
      in_act  = act;
      in_last = last;
      @(negedge clk);
      in_v    = 1'b0;
      in_last = 1'b0;
      if (gap_en) begin
         gap = $urandom_range(3, 0);           // 0 to 3 idle cycles
         repeat (gap) @(negedge clk);
      end
   endtask

   task automatic run_record(input string rec);
      int n;
      int f0, f1, f2, f3, f4, f5;
      case (rec[0])
         "W": begin
            n = $sscanf(rec, "W %d %d %d %d %d %d", f0, f1, f2, f3, f4, f5);
            if (n != 6) bad_record(rec);
            write_weights(f0, f1, pack_lanes(f2, f3, f4, f5));
         end
         "A": begin
            n = $sscanf(rec, "A %d %d %d %d %d", f0, f1, f2, f3, f4);
            if (n != 5) bad_record(rec);
            drive_beat(pack_lanes(f0, f1, f2, f3), f4 != 0);
         end
         "E": begin
            n = $sscanf(rec, "E %d %d", f0, f1);
            if (n != 2) bad_record(rec);
            exp_pe_q.push_back(f0);
            exp_val_q.push_back(f1);
         end
         "G": begin
            n = $sscanf(rec, "G %d", f0);
            if (n != 1) bad_record(rec);
            gap_en = (f0 != 0);
         end
         default: bad_record(rec);
      endcase
   endtask

   // outputs change on posedge, sampled mid cycle
   always @(negedge clk) begin : monitor
      if (rst_n && out_v) begin
         if (exp_pe_q.size() == 0) begin
            $display("output from PE %0d at %0t ns with no result expected", out_pe, $time);
            $display("Result: FAILED");
            $fatal(1, "unexpected output");
         end else begin
            check(out_pe, exp_pe_q.pop_front(), "out_pe");
            check(out_data, exp_val_q.pop_front(), "out_data");
         end
      end
   end

   initial begin : stimulus
      void'($urandom(SEED));                   // one seed for the whole run
      rst_n    = 1'b0;
      wgt_we   = 1'b0;
      wgt_pe   = '0;
      wgt_addr = '0;
      wgt_data = '0;
      in_v     = 1'b0;
      in_last  = 1'b0;
      in_act   = '0;
      gap_en   = 1'b0;
      load_records();
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      foreach (recs[i]) begin
         run_record(recs[i]);
      end
      repeat (OUT_LAT + 3) @(negedge clk);     // last results plus margin
      @(posedge clk);
      if (exp_pe_q.size() != 0) begin
         $display("%0d expected results never appeared", exp_pe_q.size());
         $display("Result: FAILED");
         $fatal(1, "missing results");
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

   initial begin : watchdog
      wait (n_rec > 0);
      repeat (n_rec * CYC_PER_REC + RST_CYCLES) @(posedge clk);
      $display("timeout: the run did not finish in the time its records allow");
      $display("Result: FAILED");
      $fatal(1, "watchdog timeout");
   end

endmodule : mvu_tb

`default_nettype wire

/* vlog.f */
rtl/mvu_pkg.sv
rtl/mvu_pe_adders.sv
rtl/mvu_pe_acc.sv
rtl/mvu_pe.sv
rtl/mvu_wgt_mem.sv
rtl/mvu_out_arbiter.sv
rtl/mvu_top.sv
tb/mvu_tb.sv

/* tb/mvu_golden.txt */
# records: W pe fold w0 w1 w2 w3 | A a0 a1 a2 a3 last | E pe expected | G random_gaps
# lane 0 comes first on each line; all values are signed decimal
# single fold on both PEs
W 0 0 1 2 3 4
W 1 0 -1 -2 -3 -4
A 1 2 3 4 1
E 0 30
E 1 -30
# four folds, fold 0 keeps its weights
W 0 1 2 0 -1 5
W 1 1 3 3 3 3
W 0 2 -4 1 1 1
W 1 2 0 7 0 -8
W 0 3 7 7 7 7
W 1 3 -2 1 -2 1
A 2 -1 0 3 0
A 1 1 1 1 0
A -3 2 5 -1 0
A 1 0 -1 2 1
E 0 50
E 1 24
# back to back, two folds each
A 1 0 0 0 0
A 0 0 0 1 1
E 0 6
E 1 2
A -1 -1 -1 -1 0
A 2 2 2 2 1
E 0 2
E 1 34
# same four fold stream with idle gaps
G 1
A 2 -1 0 3 0
A 1 1 1 1 0
A -3 2 5 -1 0
A 1 0 -1 2 1
E 0 50
E 1 24
# extremes over eight folds, all rows reloaded
W 0 0 -8 -8 -8 -8
W 0 1 -8 -8 -8 -8
W 0 2 -8 -8 -8 -8
W 0 3 -8 -8 -8 -8
W 0 4 -8 -8 -8 -8
W 0 5 -8 -8 -8 -8
W 0 6 -8 -8 -8 -8
W 0 7 -8 -8 -8 -8
W 1 0 7 7 7 7
W 1 1 7 7 7 7
W 1 2 7 7 7 7
W 1 3 7 7 7 7
W 1 4 7 7 7 7
W 1 5 7 7 7 7
W 1 6 7 7 7 7
W 1 7 7 7 7 7
A -8 -8 -8 -8 0
A -8 -8 -8 -8 0
A -8 -8 -8 -8 0
A -8 -8 -8 -8 0
A -8 -8 -8 -8 0
A -8 -8 -8 -8 0
A -8 -8 -8 -8 0
A -8 -8 -8 -8 1
E 0 2048
E 1 -1792
# reload one row between streams
W 1 0 1 1 1 1
A 1 1 1 1 1
E 0 -32
E 1 4
